/* source/accum_params.svh */
`ifndef ACCUM_PARAMS_SVH
`define ACCUM_PARAMS_SVH

// ---------------------------------------------------------------------------
// core widths and sizes
// ---------------------------------------------------------------------------

// accumulator and memory byte width
`define DATA_W 8

// memory address, also the jump and branch target width
`define ADDR_W 10

// opcode field, top bits of the word
`define OP_W 6

// full instruction word
`define INSTR_W 16

// data memory bytes, one per address
`define MEM_DEPTH 1024

`endif

/* source/isaPkg.sv */
`default_nettype none

`include "accum_params.svh"

package isaPkg;

	// opcodes, numbered in the order of the instruction table
	typedef enum logic [`OP_W-1:0] {
		LDA = 0, LDB, LDCA, LDCB, STA, STB,
		ADDA, ADDB, ADDCA, ADDCB, SUBA, SUBB, SUBCA, SUBCB,
		ANDA, ANDB, ANDCA, ANDCB, ORA, ORB, ORCA, ORCB,
		ASLA, ASRA, JMP,
		BAEQ, BANE, BAMI, BAPL, BBEQ, BBNE, BBMI, BBPL,
		NOP = 63
	} opcode_t;

	// ------------------------------------------------------------------------
	// three views of the same 16-bit word
	// ------------------------------------------------------------------------

	// absolute address, jmp and memory ops
	typedef struct packed {
		opcode_t op;
		logic [`ADDR_W-1:0] addr;
	} addrView_t;

	// 8-bit constant, low byte
	typedef struct packed {
		opcode_t op;
		logic [1:0] pad;
		logic [`DATA_W-1:0] constant;
	} constView_t;

	// unsigned forward offset from pc, branches only
	typedef struct packed {
		opcode_t op;
		logic [3:0] pad;
		logic [5:0] offset;
	} relView_t;

	typedef union packed {
		addrView_t addrView;
		constView_t constView;
		relView_t relView;
	} instrWord_t;

	// opcode classes
	function automatic logic writesA(opcode_t op);
		return op inside {LDA, LDCA, ADDA, ADDCA, SUBA, SUBCA, ANDA, ANDCA, ORA, ORCA,
			ASLA, ASRA};
	endfunction

	function automatic logic writesB(opcode_t op);
		return op inside {LDB, LDCB, ADDB, ADDCB, SUBB, SUBCB, ANDB, ANDCB, ORB, ORCB};
	endfunction

	// register forms read both accumulators
	function automatic logic readsA(opcode_t op);
		return op inside {STA, ADDA, ADDB, ADDCA, SUBA, SUBB, SUBCA, ANDA, ANDB, ANDCA,
			ORA, ORB, ORCA, ASLA, ASRA, BAEQ, BANE, BAMI, BAPL};
	endfunction

	function automatic logic readsB(opcode_t op);
		return op inside {STB, ADDA, ADDB, ADDCB, SUBA, SUBB, SUBCB, ANDA, ANDB, ANDCB,
			ORA, ORB, ORCB, BBEQ, BBNE, BBMI, BBPL};
	endfunction

	function automatic logic isLoad(opcode_t op);
		return op inside {LDA, LDB};
	endfunction

	function automatic logic isStore(opcode_t op);
		return op inside {STA, STB};
	endfunction

	// jmp counts as a branch that is always taken
	function automatic logic isBranch(opcode_t op);
		return op inside {[JMP:BBPL]};
	endfunction

endpackage

`default_nettype wire

/* source/ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

	// ------------------------------------------------------------------------
	// codes carried from decode to execute and writeback
	// ------------------------------------------------------------------------

	// accumulator written at writeback, 2'b11 is never produced
	typedef enum logic [1:0] {
		writeNone = 2'b00,
		writeA = 2'b01,
		writeB = 2'b10
	} accWrite_t;

	// bit 0: operand 1 from acc A, else constant
	// bit 1: operand 2 from acc B, else constant
	typedef enum logic [1:0] {
		selConstants = 2'b00,
		selAcumAConstB = 2'b01,
		selConstAAcumB = 2'b10,
		selAcumAB = 2'b11
	} opSel_t;

	// alu function
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluShl,
		aluShr,
		aluPass
	} aluOp_t;

endpackage

`default_nettype wire

/* source/accumulatorFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_params.svh"

module accumulatorFile (
	input wire logic aluClk,
	input wire logic rst,
	input ctrlPkg::accWrite_t wrSel,
	input wire logic [`DATA_W-1:0] wrData,
	output logic [`DATA_W-1:0] rdA,
	output logic [`DATA_W-1:0] rdB,
	output logic [`DATA_W-1:0] acumA,
	output logic [`DATA_W-1:0] acumB
);

	import ctrlPkg::*;

	// architectural state, cleared on reset
	always_ff @(posedge aluClk) begin
		if (rst) begin
			acumA <= '0;
			acumB <= '0;
		end else begin
			if (wrSel == writeA)
				acumA <= wrData;
			if (wrSel == writeB)
				acumB <= wrData;
		end
	end

	// write-through, decode sees the word two ahead
	assign rdA = (wrSel == writeA) ? wrData : acumA;
	assign rdB = (wrSel == writeB) ? wrData : acumB;

	// writeback only ever names one accumulator
	wrSelLegal: assert property (@(posedge aluClk) disable iff (rst)
		wrSel inside {writeNone, writeA, writeB});

endmodule

`default_nettype wire

/* source/dataMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_params.svh"

module dataMemory (
	input wire logic aluClk,
	input wire logic [`ADDR_W-1:0] addr,
	input wire logic wrEn,
	input wire logic [`DATA_W-1:0] wrData,
	output logic [`DATA_W-1:0] rdData
);

	// ---------------------------------------------------------------------------
	// single port byte ram
	// ---------------------------------------------------------------------------

	logic [`DATA_W-1:0] mem [`MEM_DEPTH];

	// read returns old contents on a same-address write
	always_ff @(posedge aluClk) begin
		if (wrEn)
			mem[addr] <= wrData;
		rdData <= mem[addr];
	end

endmodule

`default_nettype wire

/* source/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_params.svh"

module decodeStage (
	input wire logic aluClk,
	input wire logic rst,
	input wire logic instrValid,
	input isaPkg::instrWord_t instr,
	input wire logic [`ADDR_W-1:0] pc,
	input wire logic [`DATA_W-1:0] rdA,
	input wire logic [`DATA_W-1:0] rdB,
	output logic exValid,
	output isaPkg::opcode_t exOp,
	output ctrlPkg::aluOp_t exAluOp,
	output ctrlPkg::opSel_t exOpSel,
	output ctrlPkg::accWrite_t exAccWrite,
	output logic [`DATA_W-1:0] exConst,
	output logic [`DATA_W-1:0] exOperA,
	output logic [`DATA_W-1:0] exOperB,
	output logic [`ADDR_W-1:0] exTarget
);

	import isaPkg::*;
	import ctrlPkg::*;

	opcode_t op;
	aluOp_t aluOpNext;
	opSel_t opSelNext;
	accWrite_t accWriteNext;
	logic [`ADDR_W-1:0] targetNext;

	// opcode sits in the same bits in every view
	assign op = instr.addrView.op;

	// ---------------------------------------------------------------------------
	// decode
	// ---------------------------------------------------------------------------

	always_comb begin
		// loads, stores, branches and nop just pass
		case (op)
			ADDA, ADDB, ADDCA, ADDCB: aluOpNext = aluAdd;
			SUBA, SUBB, SUBCA, SUBCB: aluOpNext = aluSub;
			ANDA, ANDB, ANDCA, ANDCB: aluOpNext = aluAnd;
			ORA, ORB, ORCA, ORCB: aluOpNext = aluOr;
			ASLA: aluOpNext = aluShl;
			ASRA: aluOpNext = aluShr;
			default: aluOpNext = aluPass;
		endcase

		// an accumulator is an operand exactly when it is read
		opSelNext = opSel_t'({readsB(op), readsA(op)});

		if (writesA(op))
			accWriteNext = writeA;
		else if (writesB(op))
			accWriteNext = writeB;
		else
			accWriteNext = writeNone;

		// relative branches wrap at 1024, jmp and memory ops are absolute
		if (isBranch(op) && op != JMP)
			targetNext = pc + `ADDR_W'(instr.relView.offset);
		else
			targetNext = instr.addrView.addr;
	end

	// ---------------------------------------------------------------------------
	// decode to execute register
	// ---------------------------------------------------------------------------

	// control, idle slot becomes a bubble
	always_ff @(posedge aluClk) begin
		if (rst || !instrValid) begin
			exValid <= 1'b0;
			exOp <= NOP;
			exAccWrite <= writeNone;
		end else begin
			exValid <= 1'b1;
			exOp <= op;
			exAccWrite <= accWriteNext;
		end
	end

	// payload, ignored while exValid is low
	always_ff @(posedge aluClk) begin
		exAluOp <= aluOpNext;
		exOpSel <= opSelNext;
		exConst <= instr.constView.constant;
		exOperA <= rdA;
		exOperB <= rdB;
		exTarget <= targetNext;
	end

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input wire logic exValid,
	input isaPkg::opcode_t exOp,
	input wire logic wbValid,
	input ctrlPkg::accWrite_t wbAccWrite,
	output logic fwdA,
	output logic fwdB
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic wbHitsA;
	logic wbHitsB;

	// ---------------------------------------------------------------------------
	// execute vs writeback dependence
	// ---------------------------------------------------------------------------

	// word one ahead still in flight and not yet in the accumulators
	assign wbHitsA = wbValid && (wbAccWrite == writeA);
	assign wbHitsB = wbValid && (wbAccWrite == writeB);

	// forwarded value overrides the latched read
	// two-ahead case is already covered by the write-through read
	assign fwdA = exValid && wbHitsA && readsA(exOp);
	assign fwdB = exValid && wbHitsB && readsB(exOp);

endmodule

`default_nettype wire

/* source/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_params.svh"

module executeStage (
	input wire logic aluClk,
	input wire logic rst,
	input wire logic exValid,
	input isaPkg::opcode_t exOp,
	input ctrlPkg::aluOp_t exAluOp,
	input ctrlPkg::opSel_t exOpSel,
	input ctrlPkg::accWrite_t exAccWrite,
	input wire logic [`DATA_W-1:0] exConst,
	input wire logic [`DATA_W-1:0] exOperA,
	input wire logic [`DATA_W-1:0] exOperB,
	input wire logic [`ADDR_W-1:0] exTarget,
	input wire logic fwdA,
	input wire logic fwdB,
	input wire logic [`DATA_W-1:0] memRdData,
	output logic [`ADDR_W-1:0] memAddr,
	output logic memWrEn,
	output logic [`DATA_W-1:0] memWrData,
	output logic wbValid,
	output ctrlPkg::accWrite_t wbAccWrite,
	output logic [`DATA_W-1:0] wbData,
	output logic retireValid,
	output isaPkg::opcode_t retireOp,
	output logic [`DATA_W-1:0] retireData,
	output logic branchTaken,
	output logic [`ADDR_W-1:0] branchTarget
);

	import isaPkg::*;
	import ctrlPkg::*;

	logic [`DATA_W-1:0] srcA;
	logic [`DATA_W-1:0] srcB;
	logic [`DATA_W-1:0] oper1;
	logic [`DATA_W-1:0] oper2;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] storeData;
	logic taken;
	opcode_t wbOp;
	logic wbBranch;
	logic [`DATA_W-1:0] wbResult;
	logic [`ADDR_W-1:0] wbTarget;

	// ---------------------------------------------------------------------------
	// operands and alu
	// ---------------------------------------------------------------------------

	// one-ahead result wins over the latched read
	assign srcA = fwdA ? wbData : exOperA;
	assign srcB = fwdB ? wbData : exOperB;
	assign oper1 = exOpSel[0] ? srcA : exConst;
	assign oper2 = exOpSel[1] ? srcB : exConst;

	always_comb begin
		case (exAluOp)
			aluAdd: aluResult = oper1 + oper2;
			// constant B forms subtract the constant from B
			aluSub: aluResult = (exOpSel == selConstAAcumB) ? oper2 - oper1 : oper1 - oper2;
			aluAnd: aluResult = oper1 & oper2;
			aluOr: aluResult = oper1 | oper2;
			aluShl: aluResult = oper1 << 1;
			// sign bit kept
			aluShr: aluResult = $signed(oper1) >>> 1;
			default: aluResult = oper1;
		endcase
	end

	// zero and sign tests on the forwarded accumulator
	always_comb begin
		case (exOp)
			JMP: taken = 1'b1;
			BAEQ: taken = (srcA == '0);
			BANE: taken = (srcA != '0);
			BAMI: taken = srcA[`DATA_W-1];
			BAPL: taken = !srcA[`DATA_W-1];
			BBEQ: taken = (srcB == '0);
			BBNE: taken = (srcB != '0);
			BBMI: taken = srcB[`DATA_W-1];
			BBPL: taken = !srcB[`DATA_W-1];
			default: taken = 1'b0;
		endcase
	end

	// memory, read data comes back in writeback
	assign storeData = (exOp == STA) ? srcA : srcB;
	assign memAddr = exTarget;
	assign memWrEn = exValid && isStore(exOp);
	assign memWrData = storeData;

	// ---------------------------------------------------------------------------
	// execute to writeback register
	// ---------------------------------------------------------------------------

	always_ff @(posedge aluClk) begin
		if (rst) begin
			wbValid <= 1'b0;
			wbOp <= NOP;
			wbAccWrite <= writeNone;
			wbBranch <= 1'b0;
		end else begin
			wbValid <= exValid;
			wbOp <= exOp;
			wbAccWrite <= exAccWrite;
			wbBranch <= exValid && taken;
		end
	end

	always_ff @(posedge aluClk) begin
		wbResult <= isStore(exOp) ? storeData : aluResult;
		wbTarget <= exTarget;
	end

	// load data arrives from the ram this cycle
	assign wbData = isLoad(wbOp) ? memRdData : wbResult;

	// ---------------------------------------------------------------------------
	// retire register, same edge as the accumulator write
	// ---------------------------------------------------------------------------

	always_ff @(posedge aluClk) begin
		if (rst) begin
			retireValid <= 1'b0;
			retireOp <= NOP;
			retireData <= '0;
			branchTaken <= 1'b0;
			branchTarget <= '0;
		end else begin
			retireValid <= wbValid;
			retireOp <= wbOp;
			// zero unless an accumulator or memory byte was written
			retireData <= (wbAccWrite != writeNone || isStore(wbOp)) ? wbData : '0;
			branchTaken <= wbBranch;
			branchTarget <= wbBranch ? wbTarget : '0;
		end
	end

	// branch words never reach the accumulators
	branchNoAccWrite: assert property (@(posedge aluClk) disable iff (rst)
		(wbValid && isBranch(wbOp)) |-> (wbAccWrite == writeNone));

endmodule

`default_nettype wire

/* source/accumCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_params.svh"

module accumCore (
	input wire logic aluClk,
	input wire logic rst,
	input wire logic instrValid,
	input isaPkg::instrWord_t instr,
	input wire logic [`ADDR_W-1:0] pc,
	output logic retireValid,
	output isaPkg::opcode_t retireOp,
	output logic [`DATA_W-1:0] retireData,
	output logic branchTaken,
	output logic [`ADDR_W-1:0] branchTarget,
	output logic [`DATA_W-1:0] acumA,
	output logic [`DATA_W-1:0] acumB
);

	import isaPkg::*;
	import ctrlPkg::*;

	// ---------------------------------------------------------------------------
	// stage wiring
	// ---------------------------------------------------------------------------

	// accumulator reads into decode
	logic [`DATA_W-1:0] rdA;
	logic [`DATA_W-1:0] rdB;

	// decode to execute
	logic exValid;
	opcode_t exOp;
	aluOp_t exAluOp;
	opSel_t exOpSel;
	accWrite_t exAccWrite;
	logic [`DATA_W-1:0] exConst;
	logic [`DATA_W-1:0] exOperA;
	logic [`DATA_W-1:0] exOperB;
	logic [`ADDR_W-1:0] exTarget;

	// forwarding selects
	logic fwdA;
	logic fwdB;

	// ram port
	logic [`ADDR_W-1:0] memAddr;
	logic memWrEn;
	logic [`DATA_W-1:0] memWrData;
	logic [`DATA_W-1:0] memRdData;

	// writeback
	logic wbValid;
	accWrite_t wbAccWrite;
	logic [`DATA_W-1:0] wbData;

	decodeStage decodeStage_i (
		.aluClk(aluClk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc),
		.rdA(rdA), .rdB(rdB), .exValid(exValid), .exOp(exOp), .exAluOp(exAluOp),
		.exOpSel(exOpSel), .exAccWrite(exAccWrite), .exConst(exConst),
		.exOperA(exOperA), .exOperB(exOperB), .exTarget(exTarget)
	);

	hazardUnit hazardUnit_i (
		.exValid(exValid), .exOp(exOp), .wbValid(wbValid), .wbAccWrite(wbAccWrite),
		.fwdA(fwdA), .fwdB(fwdB)
	);

	executeStage executeStage_i (
		.aluClk(aluClk), .rst(rst), .exValid(exValid), .exOp(exOp), .exAluOp(exAluOp),
		.exOpSel(exOpSel), .exAccWrite(exAccWrite), .exConst(exConst),
		.exOperA(exOperA), .exOperB(exOperB), .exTarget(exTarget),
		.fwdA(fwdA), .fwdB(fwdB), .memRdData(memRdData), .memAddr(memAddr),
		.memWrEn(memWrEn), .memWrData(memWrData), .wbValid(wbValid),
		.wbAccWrite(wbAccWrite), .wbData(wbData), .retireValid(retireValid),
		.retireOp(retireOp), .retireData(retireData), .branchTaken(branchTaken),
		.branchTarget(branchTarget)
	);

	accumulatorFile accumulatorFile_i (
		.aluClk(aluClk), .rst(rst), .wrSel(wbAccWrite), .wrData(wbData),
		.rdA(rdA), .rdB(rdB), .acumA(acumA), .acumB(acumB)
	);

	dataMemory dataMemory_i (
		.aluClk(aluClk), .addr(memAddr), .wrEn(memWrEn), .wrData(memWrData),
		.rdData(memRdData)
	);

endmodule

`default_nettype wire

/* bench/refModel.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// ---------------------------------------------------------------------------
// expected retire fields, one entry per accepted word
// ---------------------------------------------------------------------------

typedef struct packed {
	opcode_t op;
	logic [`DATA_W-1:0] data;
	logic taken;
	logic [`ADDR_W-1:0] target;
	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;
	int idx;
	int acceptCycle;
} retireExp_t;

// where a result goes
localparam logic [1:0] toNone = 2'd0;
localparam logic [1:0] toA = 2'd1;
localparam logic [1:0] toB = 2'd2;
localparam logic [1:0] toMem = 2'd3;

// architectural state, one word at a time
logic [`DATA_W-1:0] modelA;
logic [`DATA_W-1:0] modelB;
logic [`DATA_W-1:0] modelMem [`MEM_DEPTH];
logic modelStored [`MEM_DEPTH];

function automatic void resetModel();
	modelA = '0;
	modelB = '0;
	foreach (modelStored[i])
		modelStored[i] = 1'b0;
endfunction

// apply one word in program order
function automatic retireExp_t refStep(input logic [`INSTR_W-1:0] word,
		input logic [`ADDR_W-1:0] wordPc);
	opcode_t op;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] k;
	logic [`ADDR_W-1:0] relTarget;
	logic [1:0] dest;
	logic [`DATA_W-1:0] res;
	logic taken;
	retireExp_t r;
	op = opcode_t'(word[15:10]);
	addr = word[9:0];
	k = word[7:0];
	// forward offset, wraps at the top of the address space
	relTarget = wordPc + {4'b0000, word[5:0]};
	dest = toNone;
	res = '0;
	taken = 1'b0;
	case (op)
		LDA: {dest, res} = {toA, modelMem[addr]};
		LDB: {dest, res} = {toB, modelMem[addr]};
		LDCA: {dest, res} = {toA, k};
		LDCB: {dest, res} = {toB, k};
		STA: {dest, res} = {toMem, modelA};
		STB: {dest, res} = {toMem, modelB};
		ADDA: {dest, res} = {toA, modelA + modelB};
		ADDB: {dest, res} = {toB, modelA + modelB};
		ADDCA: {dest, res} = {toA, modelA + k};
		ADDCB: {dest, res} = {toB, modelB + k};
		// register subtract is always a minus b
		SUBA: {dest, res} = {toA, modelA - modelB};
		SUBB: {dest, res} = {toB, modelA - modelB};
		SUBCA: {dest, res} = {toA, modelA - k};
		SUBCB: {dest, res} = {toB, modelB - k};
		ANDA: {dest, res} = {toA, modelA & modelB};
		ANDB: {dest, res} = {toB, modelA & modelB};
		ANDCA: {dest, res} = {toA, modelA & k};
		ANDCB: {dest, res} = {toB, modelB & k};
		ORA: {dest, res} = {toA, modelA | modelB};
		ORB: {dest, res} = {toB, modelA | modelB};
		ORCA: {dest, res} = {toA, modelA | k};
		ORCB: {dest, res} = {toB, modelB | k};
		ASLA: {dest, res} = {toA, modelA[6:0], 1'b0};
		// arithmetic, sign bit copied down
		ASRA: {dest, res} = {toA, modelA[7], modelA[7:1]};
		JMP: taken = 1'b1;
		BAEQ: taken = (modelA == 8'h00);
		BANE: taken = (modelA != 8'h00);
		BAMI: taken = modelA[7];
		BAPL: taken = !modelA[7];
		BBEQ: taken = (modelB == 8'h00);
		BBNE: taken = (modelB != 8'h00);
		BBMI: taken = modelB[7];
		BBPL: taken = !modelB[7];
		default: ;
	endcase
	case (dest)
		toA: modelA = res;
		toB: modelB = res;
		toMem: begin
			modelMem[addr] = res;
			modelStored[addr] = 1'b1;
		end
		default: ;
	endcase
	r = '0;
	r.op = op;
	r.data = res;
	r.taken = taken;
	if (taken)
		r.target = (op == JMP) ? addr : relTarget;
	r.a = modelA;
	r.b = modelB;
	return r;
endfunction

`endif

/* bench/accumCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accum_params.svh"

module accumCore_tb;

	import isaPkg::*;

	localparam int resetCycles = 10;
	localparam int numWords = 1200;
	// idle slots are about one in eight, so this leaves wide margin
	localparam int cycleLimit = numWords * 5 / 3;

	logic aluClk;
	logic rst;
	logic instrValid;
	instrWord_t instr;
	logic [`ADDR_W-1:0] pc;
	logic retireValid;
	opcode_t retireOp;
	logic [`DATA_W-1:0] retireData;
	logic branchTaken;
	logic [`ADDR_W-1:0] branchTarget;
	logic [`DATA_W-1:0] acumA;
	logic [`DATA_W-1:0] acumB;

	`include "refModel.svh"

	retireExp_t expQ[$];
	retireExp_t head;
	retireExp_t exp;
	opcode_t headOp;
	string opName;
	logic [15:0] lfsr;
	logic [15:0] bits;
	logic [`INSTR_W-1:0] word;
	logic [`ADDR_W-1:0] wordPc;
	int cycle;
	int resetErrors;
	int dataErrors;
	int branchErrors;
	int accErrors;
	int timingErrors;

	accumCore accumCore_i (
		.aluClk(aluClk), .rst(rst), .instrValid(instrValid), .instr(instr), .pc(pc),
		.retireValid(retireValid), .retireOp(retireOp), .retireData(retireData),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.acumA(acumA), .acumB(acumB)
	);

	always #2 aluClk = ~aluClk;

	// ------------------------------------------------------------------------
	// stimulus source
	// ------------------------------------------------------------------------

	function automatic logic [15:0] galoisNext(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[14:0], lfsr[0]};
			lfsr = galoisNext(lfsr);
		end
		return r;
	endfunction

	task automatic makeWord(output logic [`INSTR_W-1:0] w, output logic [`ADDR_W-1:0] wPc);
		logic [15:0] r;
		logic [5:0] pick;
		logic [`ADDR_W-1:0] field;
		opcode_t op;
		r = randBits(6);
		pick = r[5:0];
		// fold onto the 34 kept opcodes, last slot is nop
		if (pick > 6'd33)
			pick = pick - 6'd34;
		op = (pick == 6'd33) ? NOP : opcode_t'(pick);
		r = randBits(10);
		field = r[9:0];
		// memory traffic kept in the first 16 bytes
		if (op inside {LDA, LDB, STA, STB})
			field = {6'b000000, r[3:0]};
		// never read a byte nobody wrote
		if (op == LDA && !modelStored[field]) begin
			op = LDCA;
			field = r[9:0];
		end
		if (op == LDB && !modelStored[field]) begin
			op = LDCB;
			field = r[9:0];
		end
		r = randBits(10);
		wPc = r[9:0];
		w = {op, field};
	endtask

	task automatic printCounts();
		$display("errors: reset %0d, data %0d, branch %0d, accumulator %0d, timing %0d",
			resetErrors, dataErrors, branchErrors, accErrors, timingErrors);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		aluClk = 1'b0;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		cycle = 0;
		lfsr = 16'd72;
		resetErrors = 0;
		dataErrors = 0;
		branchErrors = 0;
		accErrors = 0;
		timingErrors = 0;
		resetModel();
		repeat (resetCycles) @(posedge aluClk);
		@(negedge aluClk);
		rst = 1'b0;

		// idle core right after reset
		@(negedge aluClk);
		if (retireValid !== 1'b0) begin
			resetErrors++;
			$display("Error reset retireValid: expected 0, actual %b", retireValid);
		end
		if (branchTaken !== 1'b0) begin
			resetErrors++;
			$display("Error reset branchTaken: expected 0, actual %b", branchTaken);
		end
		if (acumA !== 8'h00 || acumB !== 8'h00) begin
			resetErrors++;
			$display("Error reset acumA/acumB: expected 00/00, actual %h/%h", acumA, acumB);
		end

		for (int n = 0; n < numWords; n++) begin
			@(negedge aluClk);
			bits = randBits(3);
			// bubbles between words
			while (bits[2:0] == 3'd0) begin
				instrValid = 1'b0;
				@(negedge aluClk);
				bits = randBits(3);
			end
			makeWord(word, wordPc);
			exp = refStep(word, wordPc);
			exp.idx = n;
			exp.acceptCycle = cycle + 1;
			expQ.push_back(exp);
			instrValid = 1'b1;
			instr = word;
			pc = wordPc;
		end
		@(negedge aluClk);
		instrValid = 1'b0;

		// drain, then a short window for stray retires
		while (expQ.size() != 0)
			@(negedge aluClk);
		repeat (2) @(negedge aluClk);
		printCounts();
		if (resetErrors + dataErrors + branchErrors + accErrors + timingErrors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// ------------------------------------------------------------------------
	// compare, outputs settled since the rising edge
	// ------------------------------------------------------------------------

	always @(negedge aluClk) begin
		if (!rst) begin
			if (retireValid) begin
				if (expQ.size() == 0) begin
					timingErrors++;
					$display("retireValid high at cycle %0d with no word in flight", cycle);
				end else begin
					head = expQ.pop_front();
					headOp = head.op;
					opName = headOp.name();
					if (cycle != head.acceptCycle + 2) begin
						timingErrors++;
						$display("Error word %0d %s retire cycle: expected %0d, actual %0d",
							head.idx, opName, head.acceptCycle + 2, cycle);
					end
					if (retireOp !== head.op) begin
						dataErrors++;
						$display("Error word %0d %s retireOp: expected %h, actual %h",
							head.idx, opName, head.op, retireOp);
					end
					if (retireData !== head.data) begin
						dataErrors++;
						$display("Error word %0d %s retireData: expected %h, actual %h",
							head.idx, opName, head.data, retireData);
					end
					if (branchTaken !== head.taken) begin
						branchErrors++;
						$display("Error word %0d %s branchTaken: expected %b, actual %b",
							head.idx, opName, head.taken, branchTaken);
					end
					if (branchTarget !== head.target) begin
						branchErrors++;
						$display("Error word %0d %s branchTarget: expected %h, actual %h",
							head.idx, opName, head.target, branchTarget);
					end
					if (acumA !== head.a) begin
						accErrors++;
						$display("Error word %0d %s acumA: expected %h, actual %h",
							head.idx, opName, head.a, acumA);
					end
					if (acumB !== head.b) begin
						accErrors++;
						$display("Error word %0d %s acumB: expected %h, actual %h",
							head.idx, opName, head.b, acumB);
					end
				end
			end else if (expQ.size() != 0 && cycle > expQ[0].acceptCycle + 2) begin
				// overdue word, drop it so later words still line up
				head = expQ.pop_front();
				timingErrors++;
				$display("word %0d did not retire two cycles after it was accepted", head.idx);
			end
		end
	end

	// watchdog
	always @(posedge aluClk) begin
		cycle = cycle + 1;
		if (cycle >= cycleLimit) begin
			$display("timeout after %0d cycles, %0d words still in flight", cycle, expQ.size());
			printCounts();
			$display("sim failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
+incdir+bench
source/isaPkg.sv
source/ctrlPkg.sv
source/accumulatorFile.sv
source/dataMemory.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/accumCore.sv
bench/accumCore_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module accumCore_tb -f src.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "sim passed" ||
exit 1
